//--- list.f
src/xbar_pkg.sv
src/xbar_bus_regs.sv
src/xbar_program_sequencer.sv
src/xbar_bit_serializer.sv
src/xbar_control_top.sv
verification/xbar_control_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the crossbar controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  --top-module xbar_control_tb \
  --Mdir obj_dir \
  -o xbar_sim \
  -f list.f

./obj_dir/xbar_sim > sim.log 2>&1 || true
cat sim.log

# pass only if the testbench printed its pass line
if grep -qx "ALL CHECKS PASSED" sim.log; then
  echo "simulation result: pass"
  exit 0
else
  echo "simulation result: fail"
  exit 1
fi

//--- src/xbar_bit_serializer.sv
`timescale 1ns/1ps

module xbar_bit_serializer (
  input  logic                           sclk,
  input  logic                           reset,
  input  logic                           load_word,  // capture image_word
  input  logic                           shift_en,   // move one bit out
  input  logic [xbar_pkg::word_bits-1:0] image_word, // word from the store
  output logic                           sin         // serial data to the crossbar
);

  // ------------------------------------------------------------------
  // load / shift register
  // ------------------------------------------------------------------
  logic [xbar_pkg::word_bits-1:0] shift_reg;

  always_ff @(posedge sclk) begin
    if (reset) begin
      shift_reg <= '0; // sin low out of reset
    end else if (load_word) begin
      shift_reg <= image_word; // msb shows on sin next cycle
    end else if (shift_en) begin
      shift_reg <= {shift_reg[xbar_pkg::word_bits-2:0], 1'b0}; // msb first
    end else begin
      shift_reg <= '0; // line idles low outside a word
    end
  end

  // after 16 shifts the register is empty, so the load cycle
  // between words also sees sin low

  assign sin = shift_reg[xbar_pkg::word_bits-1];

endmodule

//--- src/xbar_bus_regs.sv
`timescale 1ns/1ps

module xbar_bus_regs (
  input  logic                              sclk,
  input  logic                              reset,
  input  logic                              enable,     // chip enable from the bus
  input  logic                              re,         // read strobe, one cycle
  input  logic                              wr,         // write strobe, one cycle
  input  logic [xbar_pkg::addr_w-1:0]       addr,
  input  logic [xbar_pkg::word_bits-1:0]    data,
  input  logic                              busy,       // from the sequencer
  input  logic [xbar_pkg::word_index_w-1:0] word_index, // word the sequencer wants
  output logic [xbar_pkg::word_bits-1:0]    data_out,
  output logic                              start,      // one-cycle command pulse
  output logic [xbar_pkg::word_bits-1:0]    image_word  // store[word_index], no delay
);

  // ------------------------------------------------------------------
  // address decode
  // ------------------------------------------------------------------
  logic                  sel;       // this controller is addressed
  xbar_pkg::addr_low_t   addr_low;  // low byte, both views
  logic                  locked;    // cycle running or about to run
  logic                  wr_image;
  logic                  wr_command;

  assign sel = enable &&
               (addr[xbar_pkg::addr_w-1:xbar_pkg::pos_lsb] == xbar_pkg::ctrl_position);

  assign addr_low = xbar_pkg::addr_low_t'(addr[7:0]);

  // start counts as busy too, else a second command could slip in
  // the cycle before the sequencer leaves idle
  assign locked = busy | start;

  assign wr_image   = sel && wr && !locked &&
                      (addr_low.fields.region == xbar_pkg::region_image);
  assign wr_command = sel && wr && !locked &&
                      (addr_low.fields.region == xbar_pkg::region_command);

  // ------------------------------------------------------------------
  // image store
  // ------------------------------------------------------------------
  logic [xbar_pkg::word_bits-1:0] image_mem [xbar_pkg::image_words];

  always_ff @(posedge sclk) begin
    if (reset) begin
      for (int i = 0; i < xbar_pkg::image_words; i++) begin
        image_mem[i] <= '0; // switches all open after reset
      end
    end else if (wr_image) begin
      image_mem[addr_low.fields.word] <= data;
    end
  end

  assign image_word = image_mem[word_index]; // async read for the load cycle

  // ------------------------------------------------------------------
  // command strobe
  // ------------------------------------------------------------------
  // a zero command is accepted on the bus but does nothing
  always_ff @(posedge sclk) begin
    if (reset) begin
      start <= 1'b0;
    end else begin
      start <= wr_command && (data != '0); // high the cycle after the write
    end
  end

  // ------------------------------------------------------------------
  // readback
  // ------------------------------------------------------------------
  logic [xbar_pkg::word_bits-1:0] read_value;

  always_comb begin
    unique case (addr_low.reg_code)
      xbar_pkg::reg_id:   read_value = xbar_pkg::id_word;
      xbar_pkg::reg_busy: read_value = {{(xbar_pkg::word_bits-1){1'b0}}, busy};
      default:            read_value = '0; // unmapped codes read zero
    endcase
  end

  always_ff @(posedge sclk) begin
    if (reset) begin
      data_out <= '0;
    end else if (sel && re) begin
      data_out <= read_value; // valid one cycle after re
    end else begin
      data_out <= '0; // bus is or-ed, keep quiet otherwise
    end
  end

endmodule

//--- src/xbar_control_top.sv
`timescale 1ns/1ps

module xbar_control_top (
  input  logic                           sclk,
  input  logic                           reset,
  input  logic                           enable,            // bus chip enable
  input  logic                           re,                // read strobe
  input  logic                           wr,                // write strobe
  input  logic [xbar_pkg::addr_w-1:0]    addr,
  input  logic [xbar_pkg::word_bits-1:0] data,
  output logic [xbar_pkg::word_bits-1:0] data_out,
  output logic                           sin,               // serial switch data
  output logic                           xbar_clock_enable, // crossbar clock gate
  output logic                           pclk               // switch latch, active low
);

  // ------------------------------------------------------------------
  // internal nets
  // ------------------------------------------------------------------
  logic                              start;      // regs -> sequencer
  logic                              busy;       // sequencer -> regs
  logic [xbar_pkg::word_index_w-1:0] word_index; // sequencer -> regs
  logic [xbar_pkg::word_bits-1:0]    image_word; // regs -> serializer
  logic                              load_word;  // sequencer -> serializer
  logic                              shift_en;   // sequencer -> serializer

  // bus side
  xbar_bus_regs bus_regs_i (
    .sclk       (sclk),
    .reset      (reset),
    .enable     (enable),
    .re         (re),
    .wr         (wr),
    .addr       (addr),
    .data       (data),
    .busy       (busy),
    .word_index (word_index),
    .data_out   (data_out),
    .start      (start),
    .image_word (image_word)
  );

  // programming fsm
  xbar_program_sequencer sequencer_i (
    .sclk              (sclk),
    .reset             (reset),
    .start             (start),
    .busy              (busy),
    .load_word         (load_word),
    .shift_en          (shift_en),
    .xbar_clock_enable (xbar_clock_enable),
    .pclk              (pclk),
    .word_index        (word_index)
  );

  // crossbar data line
  xbar_bit_serializer serializer_i (
    .sclk       (sclk),
    .reset      (reset),
    .load_word  (load_word),
    .shift_en   (shift_en),
    .image_word (image_word),
    .sin        (sin)
  );

endmodule

//--- src/xbar_pkg.sv
package xbar_pkg;

  // ------------------------------------------------------------------
  // bus position and address map
  // ------------------------------------------------------------------
  localparam int addr_w   = 19;           // full processor address
  localparam int pos_lsb  = 8;            // position field starts here
  localparam logic [10:0] ctrl_position = 11'd0; // matched against addr[18:8]

  // write regions, upper 3 bits of the low address byte
  localparam logic [2:0] region_image   = 3'd0;
  localparam logic [2:0] region_command = 3'd1;

  // read register codes, whole low byte
  localparam logic [7:0] reg_id   = 8'h09;
  localparam logic [7:0] reg_busy = 8'h0A;

  localparam logic [15:0] id_word = 16'h7ba2; // fixed identity

  // ------------------------------------------------------------------
  // image geometry
  // ------------------------------------------------------------------
  localparam int image_words  = 32;   // 512 switch bits in total
  localparam int word_bits    = 16;
  localparam int word_index_w = 5;    // log2(image_words)
  localparam int bit_index_w  = 4;    // log2(word_bits)
  localparam int cnt_w        = word_index_w + bit_index_w; // 9-bit bit counter

  // ------------------------------------------------------------------
  // sequencer states, one-hot
  // ------------------------------------------------------------------
  localparam int state_w = 4;
  localparam logic [state_w-1:0] st_idle  = 4'b0001; // waiting for a command
  localparam logic [state_w-1:0] st_load  = 4'b0010; // fetch next word
  localparam logic [state_w-1:0] st_shift = 4'b0100; // 16 bits out on sin
  localparam logic [state_w-1:0] st_pulse = 4'b1000; // pclk low, latch switches

  // ------------------------------------------------------------------
  // low address byte, two decodes
  // ------------------------------------------------------------------
  // writes split the byte into region and word
  typedef struct packed {
    logic [2:0]              region; // image or command
    logic [word_index_w-1:0] word;   // image word number
  } addr_fields_t;

  // reads take the byte as one register code
  typedef union packed {
    logic [7:0]   reg_code;
    addr_fields_t fields;
  } addr_low_t;

endpackage

//--- src/xbar_program_sequencer.sv
`timescale 1ns/1ps

module xbar_program_sequencer (
  input  logic                              sclk,
  input  logic                              reset,
  input  logic                              start,             // one-cycle command pulse
  output logic                              busy,              // not idle
  output logic                              load_word,         // serializer load
  output logic                              shift_en,          // serializer shift
  output logic                              xbar_clock_enable, // gates the crossbar clock
  output logic                              pclk,              // latch, active low
  output logic [xbar_pkg::word_index_w-1:0] word_index         // word being fetched
);

  // ------------------------------------------------------------------
  // state and bit counter
  // ------------------------------------------------------------------
  logic [xbar_pkg::state_w-1:0] state;
  logic [xbar_pkg::state_w-1:0] state_next;
  logic [xbar_pkg::cnt_w-1:0]   bit_count;  // {word, bit} of the current bit
  logic                         word_done;  // last bit of a word on sin
  logic                         image_done; // last bit of the whole image

  assign word_done  = &bit_count[xbar_pkg::bit_index_w-1:0];
  assign image_done = &bit_count; // 511

  // upper counter bits pick the word; during load the low bits are zero
  assign word_index = bit_count[xbar_pkg::cnt_w-1 -: xbar_pkg::word_index_w];

  // ------------------------------------------------------------------
  // next state
  // ------------------------------------------------------------------
  always_comb begin
    state_next = state;
    unique case (state)
      xbar_pkg::st_idle: begin
        if (start) begin
          state_next = xbar_pkg::st_load; // word 0 load next cycle
        end
      end
      xbar_pkg::st_load: begin
        state_next = xbar_pkg::st_shift; // always one load cycle
      end
      xbar_pkg::st_shift: begin
        if (image_done) begin
          state_next = xbar_pkg::st_pulse;
        end else if (word_done) begin
          state_next = xbar_pkg::st_load; // fetch following word
        end
      end
      xbar_pkg::st_pulse: begin
        state_next = xbar_pkg::st_idle; // single latch cycle
      end
      default: begin
        state_next = xbar_pkg::st_idle; // illegal code, recover
      end
    endcase
  end

  // ------------------------------------------------------------------
  // registers
  // ------------------------------------------------------------------
  // enable and pclk come from state_next so they sit in the same cycles
  // as the serializer's output bit and the pulse state
  always_ff @(posedge sclk) begin
    if (reset) begin
      state             <= xbar_pkg::st_idle;
      bit_count         <= '0;
      xbar_clock_enable <= 1'b0;
      pclk              <= 1'b1;
    end else begin
      state             <= state_next;
      xbar_clock_enable <= (state_next == xbar_pkg::st_shift);
      pclk              <= (state_next != xbar_pkg::st_pulse); // low one cycle
      if (state == xbar_pkg::st_idle) begin
        bit_count <= '0; // next cycle starts at word 0 bit 0
      end else if (state == xbar_pkg::st_shift) begin
        bit_count <= bit_count + 1'b1; // wraps to 0 after 511
      end
    end
  end

  // ------------------------------------------------------------------
  // decoded controls
  // ------------------------------------------------------------------
  assign busy      = (state != xbar_pkg::st_idle);  // includes the pulse cycle
  assign load_word = (state == xbar_pkg::st_load);
  assign shift_en  = (state == xbar_pkg::st_shift);

endmodule

//--- verification/xbar_control_tb.sv
`timescale 1ns/1ps

module xbar_control_tb;

  // ------------------------------------------------------------------
  // table row layout and operations
  // ------------------------------------------------------------------
  localparam logic [2:0] op_write_image = 3'd0;
  localparam logic [2:0] op_write_cmd   = 3'd1;
  localparam logic [2:0] op_read        = 3'd2;
  localparam logic [2:0] op_wait_done   = 3'd3; // wait for pclk and check the stream
  localparam logic [2:0] op_quiet       = 3'd4; // 600 cycles with no activity

  typedef struct packed {
    logic [2:0]  op;
    logic        en;      // chip enable during the access
    logic [18:0] addr;
    logic [15:0] data;
    logic [15:0] exp_val; // reads only
  } row_t;

  logic        sclk, reset, enable, re, wr;
  logic [18:0] addr;
  logic [15:0] data;
  logic [15:0] data_out;
  logic        sin, xbar_clock_enable, pclk;

  row_t        rows[$];
  logic [15:0] model_img [32]; // expected switch image
  bit          exp_bits[$];
  bit          captured[$];    // sin while the clock enable is high
  bit          running;        // a cycle was started and not yet seen done
  bit          table_ready;
  bit          last_en, en_before_pulse;
  int          pulse_count, bits_at_pulse, cap_base, pulse_base;
  int          word_errors, bit_errors, count_errors;
  logic [31:0] lcg_state;

  xbar_control_top dut_i (
    .sclk (sclk), .reset (reset), .enable (enable), .re (re), .wr (wr),
    .addr (addr), .data (data), .data_out (data_out), .sin (sin),
    .xbar_clock_enable (xbar_clock_enable), .pclk (pclk)
  );

  initial begin
    sclk = 1'b0;
    forever #2 sclk = ~sclk; // 4 ns period
  end

  // ------------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------------
  function automatic logic [15:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16]; // upper half has the better bits
  endfunction

  function automatic logic [18:0] image_addr(logic [10:0] pos, logic [4:0] word);
    xbar_pkg::addr_low_t low;
    low.fields.region = xbar_pkg::region_image;
    low.fields.word   = word;
    return {pos, low.reg_code};
  endfunction

  function automatic logic [18:0] cmd_addr(logic [10:0] pos);
    xbar_pkg::addr_low_t low;
    low.fields.region = xbar_pkg::region_command;
    low.fields.word   = 5'd0;
    return {pos, low.reg_code};
  endfunction

  function automatic logic [18:0] reg_addr(logic [10:0] pos, logic [7:0] code);
    xbar_pkg::addr_low_t low;
    low.reg_code = code;
    return {pos, low.reg_code};
  endfunction

  function automatic row_t make_row(logic [2:0] op, logic en, logic [18:0] a,
                                    logic [15:0] d, logic [15:0] e);
    return {op, en, a, d, e}; // field order of row_t
  endfunction

  task automatic check_word(input logic [xbar_pkg::word_bits-1:0] got,
                            input logic [xbar_pkg::word_bits-1:0] exp, input string what);
    if (got !== exp) begin
      word_errors++;
      $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      bit_errors++;
      $display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      count_errors++;
      $display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  // ------------------------------------------------------------------
  // bus accesses start and end just after a falling edge
  // ------------------------------------------------------------------
  task automatic write_bus(input row_t r);
    xbar_pkg::addr_low_t low;
    int w;
    low = xbar_pkg::addr_low_t'(r.addr[7:0]);
    {enable, wr, addr, data} = {r.en, 1'b1, r.addr, r.data};
    @(negedge sclk);
    {enable, wr} = 2'b00;
    // expected effect on the image and the run state
    if (r.en && r.addr[18:8] == xbar_pkg::ctrl_position && !running) begin
      if (low.fields.region == xbar_pkg::region_image) begin
        model_img[low.fields.word] = r.data;
      end else if (low.fields.region == xbar_pkg::region_command && r.data != 16'h0) begin
        running = 1'b1;
        cap_base = captured.size();
        pulse_base = pulse_count;
        exp_bits.delete();
        for (w = 0; w < 32; w++) begin
          for (int b = 15; b >= 0; b--) exp_bits.push_back(model_img[w][b]); // msb first
        end
      end
    end
  endtask

  task automatic read_bus(input row_t r);
    {enable, re, addr} = {r.en, 1'b1, r.addr};
    @(negedge sclk); // data_out registered at the edge in between
    {enable, re} = 2'b00;
    check_word(data_out, r.exp_val, $sformatf("read at %h", r.addr));
  endtask

  task automatic wait_done();
    int n;
    while (pulse_count == pulse_base) @(posedge sclk);
    @(posedge sclk); // monitor has seen the idle cycle after the pulse
    n = captured.size() - cap_base;
    check_count(n, 512, "bits shifted out");
    for (int i = 0; i < n && i < 512; i++) begin
      if (captured[cap_base+i] !== exp_bits[i]) begin
        check_bit(captured[cap_base+i], exp_bits[i], $sformatf("stream bit %0d", i));
        break; // first mismatch is enough
      end
    end
    check_count(bits_at_pulse - cap_base, 512, "bits before latch pulse");
    check_bit(en_before_pulse, 1'b1, "enable in cycle before pclk low");
    check_count(pulse_count - pulse_base, 1, "pclk low cycles");
    running = 1'b0;
    @(negedge sclk); // realign to the falling edge
  endtask

  task automatic stay_quiet();
    int bits0, pulses0;
    bits0 = captured.size();
    pulses0 = pulse_count;
    repeat (600) @(posedge sclk);
    check_count(captured.size() - bits0, 0, "enabled bits while idle");
    check_count(pulse_count - pulses0, 0, "pclk pulses while idle");
    @(negedge sclk);
  endtask

  // ------------------------------------------------------------------
  // monitor samples mid-cycle
  // ------------------------------------------------------------------
  always @(negedge sclk) begin
    if (!reset) begin
      if (xbar_clock_enable) captured.push_back(sin);
      if (!pclk) begin
        pulse_count++;
        bits_at_pulse = captured.size();
        en_before_pulse = last_en;
      end
      last_en = xbar_clock_enable;
    end
  end

  // watchdog scaled to the table
  initial begin
    wait (table_ready);
    repeat (rows.size() * 600 + 100) @(posedge sclk);
    $display("timeout: run did not finish within %0d cycles", rows.size() * 600 + 100);
    $display("CHECKS FAILED");
    $finish;
  end

  // ------------------------------------------------------------------
  // stimulus table and main flow
  // ------------------------------------------------------------------
  initial begin
    {reset, enable, re, wr} = 4'b1000;
    addr = '0;
    data = '0;
    lcg_state = 32'h16467a9b;
    for (int i = 0; i < 32; i++) model_img[i] = 16'h0; // store clears on reset

    // reset state and decode
    rows.push_back(make_row(op_read, 1'b1, reg_addr(11'd0, xbar_pkg::reg_busy), 16'h0, 16'h0));
    rows.push_back(make_row(op_read, 1'b1, reg_addr(11'd0, xbar_pkg::reg_id), 16'h0,
                            xbar_pkg::id_word));
    rows.push_back(make_row(op_read, 1'b1, reg_addr(11'd0, 8'h00), 16'h0, 16'h0));
    rows.push_back(make_row(op_read, 1'b1, reg_addr(11'd0, 8'h0b), 16'h0, 16'h0));
    rows.push_back(make_row(op_read, 1'b1, reg_addr(11'd1, xbar_pkg::reg_id), 16'h0, 16'h0));
    rows.push_back(make_row(op_read, 1'b0, reg_addr(11'd0, xbar_pkg::reg_id), 16'h0, 16'h0));
    // full random image
    for (int i = 0; i < 32; i++) begin
      rows.push_back(make_row(op_write_image, 1'b1, image_addr(11'd0, 5'(i)), lcg_next(),
                              16'h0));
    end
    // writes that must not land or start anything
    rows.push_back(make_row(op_write_image, 1'b1, image_addr(11'd1, 5'd3), 16'hffff, 16'h0));
    rows.push_back(make_row(op_write_image, 1'b0, image_addr(11'd0, 5'd5), 16'h1234, 16'h0));
    rows.push_back(make_row(op_write_cmd, 1'b1, cmd_addr(11'd0), 16'h0000, 16'h0)); // zero
    rows.push_back(make_row(op_write_cmd, 1'b1, cmd_addr(11'd2), 16'h0001, 16'h0));
    rows.push_back(make_row(op_write_cmd, 1'b0, cmd_addr(11'd0), 16'h0001, 16'h0));
    rows.push_back(make_row(op_quiet, 1'b0, 19'h0, 16'h0, 16'h0));
    // first cycle with writes during busy
    rows.push_back(make_row(op_write_cmd, 1'b1, cmd_addr(11'd0), 16'h0001, 16'h0));
    rows.push_back(make_row(op_write_image, 1'b1, image_addr(11'd0, 5'd0), 16'hdead, 16'h0));
    rows.push_back(make_row(op_read, 1'b1, reg_addr(11'd0, xbar_pkg::reg_busy), 16'h0, 16'h1));
    rows.push_back(make_row(op_write_cmd, 1'b1, cmd_addr(11'd0), 16'h0002, 16'h0));
    rows.push_back(make_row(op_write_image, 1'b1, image_addr(11'd0, 5'd31), 16'hbeef, 16'h0));
    rows.push_back(make_row(op_wait_done, 1'b0, 19'h0, 16'h0, 16'h0));
    rows.push_back(make_row(op_read, 1'b1, reg_addr(11'd0, xbar_pkg::reg_busy), 16'h0, 16'h0));
    rows.push_back(make_row(op_quiet, 1'b0, 19'h0, 16'h0, 16'h0)); // no second cycle
    // second cycle with a partly new image
    for (int i = 0; i < 8; i++) begin
      rows.push_back(make_row(op_write_image, 1'b1, image_addr(11'd0, 5'(i * 4)), lcg_next(),
                              16'h0));
    end
    rows.push_back(make_row(op_write_cmd, 1'b1, cmd_addr(11'd0), 16'h8000, 16'h0));
    rows.push_back(make_row(op_wait_done, 1'b0, 19'h0, 16'h0, 16'h0));
    rows.push_back(make_row(op_read, 1'b1, reg_addr(11'd0, xbar_pkg::reg_busy), 16'h0, 16'h0));
    rows.push_back(make_row(op_read, 1'b1, reg_addr(11'd0, xbar_pkg::reg_id), 16'h0,
                            xbar_pkg::id_word));
    table_ready = 1'b1;

    repeat (16) @(negedge sclk);
    reset = 1'b0;
    check_bit(xbar_clock_enable, 1'b0, "clock enable after reset");
    check_bit(pclk, 1'b1, "pclk after reset");
    check_bit(sin, 1'b0, "sin after reset");
    check_word(data_out, 16'h0, "data_out after reset");

    foreach (rows[k]) begin
      case (rows[k].op)
        op_write_image, op_write_cmd: write_bus(rows[k]);
        op_read:                      read_bus(rows[k]);
        op_wait_done:                 wait_done();
        default:                      stay_quiet();
      endcase
    end

    repeat (4) @(negedge sclk);
    $display("errors: word %0d, bit %0d, count %0d", word_errors, bit_errors, count_errors);
    if (word_errors + bit_errors + count_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule
